// ==== design/cpu_pkg.sv ====
package cpu_pkg;

    // Type-A opcodes, low nibble of the A byte
    typedef enum logic [3:0] {
        A_JMP = 4'd0,
        A_INC = 4'd1,
        A_ADD = 4'd2,
        A_DEC = 4'd3,
        A_FLP = 4'd4,
        A_NOT = 4'd5,
        A_AND = 4'd6,
        A_IOR = 4'd7,
        A_XOR = 4'd8,
        A_IN2 = 4'd9,
        A_DE2 = 4'd10,
        A_SUS = 4'd11,
        A_AUS = 4'd12,
        A_HLF = 4'd13,
        A_HIF = 4'd14,
        A_VVV = 4'd15  // Escape to B byte
    } a_op_e;

    typedef enum logic [7:0] {
        B_GPC = 8'h01, B_SSP = 8'h07, B_GSP = 8'h08,
        B_PSB = 8'h09, B_PSS = 8'h0A, B_PSW = 8'h0B, B_PSQ = 8'h0C,  // Pushes
        B_QSB = 8'h0D, B_QSS = 8'h0E, B_QSW = 8'h0F, B_QSQ = 8'h10,  // Pulls
        B_SSB = 8'h15, B_SSS = 8'h16, B_SSW = 8'h17, B_SSQ = 8'h18,  // Indexed stores
        B_LSB = 8'h19, B_LSS = 8'h1A, B_LSW = 8'h1B, B_LSQ = 8'h1C,  // Indexed loads
        B_NXR = 8'h1F, B_JMR = 8'h20, B_JRR = 8'h21,
        B_BFR = 8'h22, B_BNR = 8'h23, B_BEQ = 8'h24, B_BNE = 8'h25,
        B_CCC = 8'h2E, B_IMM = 8'h35, B_LS8 = 8'h36
    } b_op_e;

    typedef enum logic [2:0] {
        FETCH_A,
        EXEC_A,
        FETCH_B,
        EXEC_B,
        MEM,
        LINK_WAIT
    } state_e;

    typedef enum logic [1:0] {
        FETCH,
        STORE,
        LOAD
    } acc_kind_e;

    typedef logic [2:0] size_code_t;  // Byte count minus one

    localparam size_code_t SZ_BYTE = 3'd0;
    localparam size_code_t SZ_HALF = 3'd1;
    localparam size_code_t SZ_WORD = 3'd3;
    localparam size_code_t SZ_QUAD = 3'd7;

    localparam logic [3:0] PC_RESET_INDEX = 4'd0;
    localparam logic [3:0] SP_RESET_INDEX = 4'd1;

endpackage

// ==== design/insn_decoder.sv ====
`timescale 1ns/1ps

module insn_decoder import cpu_pkg::*; #(
    parameter int NREG = 16,
    localparam int IW = $clog2(NREG)
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          capture_a,
    input  logic          capture_b,
    input  logic [7:0]    fetched_byte,
    output a_op_e         a_op,
    output b_op_e         b_op,
    output logic [IW-1:0] idx_a,
    output logic [IW-1:0] idx_b,
    output logic [IW-1:0] idx_d,
    output logic          is_escape,
    output logic          is_mem,
    output acc_kind_e     mem_kind
);
    logic [7:0] a_byte;
    logic [7:0] b_byte;
    logic [3:0] base;

    always_ff @(posedge clk) begin
        if (rst) begin
            a_byte <= 8'h00;
            b_byte <= 8'h00;
        end else begin
            if (capture_a) a_byte <= fetched_byte;
            if (capture_b) b_byte <= fetched_byte;
        end
    end

    assign base = a_byte[7:4];
    assign a_op = a_op_e'(a_byte[3:0]);
    assign b_op = b_op_e'(b_byte);
    assign is_escape = (a_op == A_VVV);

    // Operands wrap around the register count
    assign idx_a = IW'(base % NREG);
    assign idx_b = IW'((base + 1) % NREG);
    assign idx_d = IW'((base + 2) % NREG);

    // Memory class, everything else is register or branch
    always_comb begin
        is_mem = 1'b0;
        mem_kind = STORE;
        if (is_escape) begin
            case (b_op)
                B_PSB, B_PSS, B_PSW, B_PSQ,
                B_SSB, B_SSS, B_SSW, B_SSQ: is_mem = 1'b1;
                B_QSB, B_QSS, B_QSW, B_QSQ,
                B_LSB, B_LSS, B_LSW, B_LSQ: begin
                    is_mem = 1'b1;
                    mem_kind = LOAD;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== design/xreg_file.sv ====
`timescale 1ns/1ps

module xreg_file import cpu_pkg::*; #(
    parameter int XLEN = 64,
    parameter int NREG = 16,
    localparam int IW = $clog2(NREG)
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [IW-1:0]   idx_a,
    input  logic [IW-1:0]   idx_b,
    input  logic [IW-1:0]   idx_d,
    output logic [XLEN-1:0] val_a,
    output logic [XLEN-1:0] val_b,
    output logic [XLEN-1:0] val_d,
    output logic [XLEN-1:0] pc_val,
    output logic [XLEN-1:0] sp_val,
    input  logic            w0_en,   // Result or load target
    input  logic [IW-1:0]   w0_idx,
    input  logic [XLEN-1:0] w0_val,
    input  logic            w1_en,   // PC
    input  logic [XLEN-1:0] w1_val,
    input  logic            w2_en,   // SP
    input  logic [XLEN-1:0] w2_val,
    input  logic            set_sp,
    input  logic [IW-1:0]   new_sp_index
);
    logic [XLEN-1:0] regs [NREG];
    logic [IW-1:0]   pc_index;
    logic [IW-1:0]   sp_index;

    assign val_a = regs[idx_a];
    assign val_b = regs[idx_b];
    assign val_d = regs[idx_d];
    assign pc_val = regs[pc_index];
    assign sp_val = regs[sp_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_index <= IW'(PC_RESET_INDEX);
            sp_index <= IW'(SP_RESET_INDEX);
            regs[IW'(PC_RESET_INDEX)] <= '0;
            regs[IW'(SP_RESET_INDEX)] <= '0;
        end else begin
            // Later port wins on the same index
            if (w0_en) regs[w0_idx] <= w0_val;
            if (w1_en) regs[pc_index] <= w1_val;
            if (w2_en) regs[sp_index] <= w2_val;
            if (set_sp) sp_index <= new_sp_index;
        end
    end

    a_pc_sp_distinct: assert property (@(posedge clk) disable iff (rst)
        pc_index != sp_index)
        else $error("SP index collides with PC index");

endmodule

// ==== design/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit import cpu_pkg::*; #(
    parameter int XLEN = 64,
    parameter int NREG = 16,
    localparam int IW = $clog2(NREG)
) (
    input  a_op_e           a_op,
    input  b_op_e           b_op,
    input  logic            is_escape,
    input  logic            is_mem,
    input  logic [XLEN-1:0] val_a,
    input  logic [XLEN-1:0] val_b,
    input  logic [XLEN-1:0] val_d,
    input  logic [XLEN-1:0] pc_val,
    input  logic [XLEN-1:0] sp_val,
    input  logic [IW-1:0]   idx_a,
    input  logic [IW-1:0]   idx_b,
    output logic [XLEN-1:0] res_val,
    output logic            res_we,
    output logic [XLEN-1:0] next_pc,
    output logic            sp_we,
    output logic [XLEN-1:0] next_sp,
    output logic [XLEN-1:0] mem_addr,
    output size_code_t      mem_size,
    output logic [XLEN-1:0] mem_data,
    output logic            mem_dir_load,
    output logic            ssp_we,
    output logic [IW-1:0]   ssp_index
);
    localparam logic [XLEN-1:0] HALF_MASK = XLEN'(32'hFFFF_FFFF);

    logic [XLEN-1:0] pc_plus1;
    logic [XLEN-1:0] nbytes;

    assign pc_plus1 = pc_val + 1'b1;  // Link value is the byte after this one
    assign nbytes = XLEN'(mem_size) + 1'b1;
    assign mem_data = val_a;
    assign ssp_index = idx_a;

    always_comb begin
        case (b_op)
            B_PSB, B_QSB, B_SSB, B_LSB: mem_size = SZ_BYTE;
            B_PSS, B_QSS, B_SSS, B_LSS: mem_size = SZ_HALF;
            B_PSW, B_QSW, B_SSW, B_LSW: mem_size = SZ_WORD;
            default: mem_size = SZ_QUAD;
        endcase
    end

    always_comb begin
        res_val = '0;
        res_we = 1'b1;
        next_pc = pc_plus1;
        sp_we = 1'b0;
        next_sp = sp_val;
        mem_addr = val_a + val_b;  // Indexed form
        mem_dir_load = 1'b0;
        ssp_we = 1'b0;
        if (!is_escape) begin
            case (a_op)
                A_JMP: begin
                    res_val = pc_plus1;
                    next_pc = val_a;
                end
                A_INC: res_val = val_a + 1'b1;
                A_ADD: res_val = val_a + val_b;
                A_DEC: res_val = val_a - 1'b1;
                A_FLP: res_val = {~val_a[XLEN-1], val_a[XLEN-2:0]};
                A_NOT: res_val = ~val_a;
                A_AND: res_val = val_a & val_b;
                A_IOR: res_val = val_a | val_b;
                A_XOR: res_val = val_a ^ val_b;
                A_IN2: res_val = val_a + 2'd2;
                A_DE2: res_val = val_a - 2'd2;
                A_SUS: res_val = val_a - val_b;
                A_AUS: res_val = val_a + val_b;
                A_HLF: res_val = val_a & HALF_MASK;
                A_HIF: res_val = val_a & ~HALF_MASK;
                default: res_we = 1'b0;
            endcase
        end else if (is_mem) begin
            res_we = 1'b0;
            case (b_op)
                B_PSB, B_PSS, B_PSW, B_PSQ: begin
                    mem_addr = sp_val;
                    next_sp = sp_val + nbytes;
                    sp_we = 1'b1;
                end
                B_QSB, B_QSS, B_QSW, B_QSQ: begin
                    mem_addr = sp_val - nbytes;  // Pull reads below SP
                    next_sp = sp_val - nbytes;
                    sp_we = 1'b1;
                    mem_dir_load = 1'b1;
                end
                B_LSB, B_LSS, B_LSW, B_LSQ: mem_dir_load = 1'b1;
                default: ;
            endcase
        end else begin
            case (b_op)
                B_GPC: res_val = pc_val;
                B_SSP: begin
                    res_we = 1'b0;
                    ssp_we = 1'b1;
                end
                B_GSP: res_val = sp_val;
                B_NXR: res_val = ~val_a + ~val_b;
                B_JMR: begin
                    res_val = pc_plus1;
                    next_pc = val_a;
                end
                B_JRR: begin
                    res_val = pc_plus1;
                    next_pc = val_a + val_b;
                end
                B_BFR: begin
                    res_we = 1'b0;
                    if (val_a == '0) next_pc = pc_val + val_d;
                end
                B_BNR: begin
                    res_we = 1'b0;
                    if (val_a != '0) next_pc = pc_val + val_d;
                end
                B_BEQ: begin
                    res_we = 1'b0;
                    if (val_a == val_b) next_pc = pc_val + val_d;
                end
                B_BNE: begin
                    res_we = 1'b0;
                    if (val_a != val_b) next_pc = pc_val + val_d;
                end
                B_CCC: res_val = '0;
                B_IMM: res_val = (XLEN'(idx_a) << 4) | XLEN'(idx_b);
                B_LS8: res_val = val_a << 8;
                default: res_we = 1'b0;  // Unknown code just advances
            endcase
        end
    end

endmodule

// ==== design/sequencer.sv ====
`timescale 1ns/1ps

module sequencer import cpu_pkg::*; #(
    parameter int XLEN = 64,
    parameter int NREG = 16,
    localparam int IW = $clog2(NREG)
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            is_escape,
    input  logic            is_mem,
    input  acc_kind_e       mem_kind,
    input  logic [IW-1:0]   idx_a,
    input  logic [IW-1:0]   idx_d,
    input  logic [XLEN-1:0] pc_val,
    input  logic [XLEN-1:0] res_val,
    input  logic            res_we,
    input  logic [XLEN-1:0] next_pc,
    input  logic            sp_we,
    input  logic [XLEN-1:0] next_sp,
    input  logic [XLEN-1:0] mem_addr,
    input  size_code_t      mem_size,
    input  logic [XLEN-1:0] mem_data,
    input  logic            mem_dir_load,
    input  logic            ssp_we,
    input  logic [IW-1:0]   ssp_index,
    input  logic            done,
    input  logic [XLEN-1:0] load_value,
    output logic            capture_a,
    output logic            capture_b,
    output logic            req_start,
    output acc_kind_e       req_kind,
    output logic [XLEN-1:0] req_addr,
    output size_code_t      req_size,
    output logic [XLEN-1:0] req_data,
    output logic            w0_en,
    output logic [IW-1:0]   w0_idx,
    output logic [XLEN-1:0] w0_val,
    output logic            w1_en,
    output logic [XLEN-1:0] w1_val,
    output logic            w2_en,
    output logic [XLEN-1:0] w2_val,
    output logic            set_sp,
    output logic [IW-1:0]   new_sp_index
);
    state_e state;
    logic   want_b;  // Pending fetch is the B byte

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH_A;
            want_b <= 1'b0;
        end else begin
            case (state)
                FETCH_A: begin
                    state <= LINK_WAIT;
                    want_b <= 1'b0;
                end
                FETCH_B: begin
                    state <= LINK_WAIT;
                    want_b <= 1'b1;
                end
                LINK_WAIT: if (done) state <= want_b ? EXEC_B : EXEC_A;
                EXEC_A: state <= is_escape ? FETCH_B : FETCH_A;
                EXEC_B: state <= is_mem ? MEM : FETCH_A;
                MEM: if (done) state <= FETCH_A;
                default: state <= FETCH_A;
            endcase
        end
    end

    assign capture_a = (state == LINK_WAIT) && done && !want_b;
    assign capture_b = (state == LINK_WAIT) && done && want_b;

    // Fetch requests use the PC, memory ops use the exec fields
    assign req_start = (state == FETCH_A) || (state == FETCH_B) || (state == EXEC_B && is_mem);
    assign req_kind = (state == EXEC_B) ? mem_kind : FETCH;
    assign req_addr = (state == EXEC_B) ? mem_addr : pc_val;
    assign req_size = (state == EXEC_B) ? mem_size : SZ_BYTE;
    assign req_data = mem_data;

    assign w0_en = (state == EXEC_A && !is_escape && res_we)
                || (state == EXEC_B && res_we)
                || (state == MEM && done && mem_dir_load);
    assign w0_idx = (state == MEM && sp_we) ? idx_a : idx_d;  // Pulls land in a
    assign w0_val = (state == MEM) ? load_value : res_val;

    assign w1_en = (state == EXEC_A) || (state == EXEC_B);
    assign w1_val = (state == EXEC_A && is_escape) ? pc_val + 1'b1 : next_pc;

    assign w2_en = (state == EXEC_B) && sp_we;
    assign w2_val = next_sp;

    assign set_sp = (state == EXEC_B) && ssp_we;
    assign new_sp_index = ssp_index;

    a_one_req_in_flight: assert property (@(posedge clk) disable iff (rst)
        req_start |=> (!req_start until_with done))
        else $error("Request issued before previous access finished");

endmodule

// ==== design/mem_port.sv ====
`timescale 1ns/1ps

module mem_port import cpu_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            req_start,
    input  acc_kind_e       req_kind,
    input  logic [XLEN-1:0] req_addr,
    input  size_code_t      req_size,
    input  logic [XLEN-1:0] req_data,
    input  logic [7:0]      rd_data,
    input  logic            rdy,
    output logic [XLEN-1:0] addr,
    output logic            wr,
    output logic            ce,
    output logic [7:0]      wr_data,
    output logic            done,
    output logic [7:0]      fetched_byte,
    output logic [XLEN-1:0] load_value
);
    size_code_t      count;    // Bytes left minus one
    logic [XLEN-1:0] shift_q;  // Store data or partial load
    logic            xfer;

    assign xfer = ce && rdy;
    assign done = xfer && (count == SZ_BYTE);
    assign wr_data = shift_q[7:0];
    assign fetched_byte = rd_data;
    assign load_value = {shift_q[XLEN-9:0], rd_data};

    always_ff @(posedge clk) begin
        if (rst) begin
            ce <= 1'b0;
            wr <= 1'b0;
            count <= SZ_BYTE;
        end else if (req_start) begin
            ce <= 1'b1;
            wr <= (req_kind == STORE);
            count <= req_size;
        end else if (xfer) begin
            if (count == SZ_BYTE) begin
                ce <= 1'b0;
                wr <= 1'b0;
            end
            count <= count - 1'b1;
        end
    end

    // Stores ascend from the base, loads descend from the top byte
    always_ff @(posedge clk) begin
        if (req_start) begin
            addr <= (req_kind == LOAD) ? req_addr + XLEN'(req_size) : req_addr;
            shift_q <= (req_kind == STORE) ? req_data : '0;
        end else if (xfer) begin
            addr <= wr ? addr + 1'b1 : addr - 1'b1;
            shift_q <= wr ? shift_q >> 8 : load_value;
        end
    end

    a_wr_needs_ce: assert property (@(posedge clk) disable iff (rst)
        wr |-> ce)
        else $error("wr asserted without ce");

    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        ce && !rdy |=> $stable(addr) && $stable(wr) && $stable(wr_data))
        else $error("Bus changed while stalled");

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
    parameter int XLEN = 64,
    parameter int NREG = 16
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [7:0]      rd_data,
    input  logic            rdy,
    output logic [XLEN-1:0] addr,
    output logic            wr,
    output logic            ce,
    output logic [7:0]      wr_data
);
    localparam int IW = $clog2(NREG);

    // Decoder
    a_op_e           a_op;
    b_op_e           b_op;
    logic [IW-1:0]   idx_a;
    logic [IW-1:0]   idx_b;
    logic [IW-1:0]   idx_d;
    logic            is_escape;
    logic            is_mem;
    acc_kind_e       mem_kind;
    logic            capture_a;
    logic            capture_b;
    logic [7:0]      fetched_byte;

    // Register file
    logic [XLEN-1:0] val_a;
    logic [XLEN-1:0] val_b;
    logic [XLEN-1:0] val_d;
    logic [XLEN-1:0] pc_val;
    logic [XLEN-1:0] sp_val;
    logic            w0_en;
    logic [IW-1:0]   w0_idx;
    logic [XLEN-1:0] w0_val;
    logic            w1_en;
    logic [XLEN-1:0] w1_val;
    logic            w2_en;
    logic [XLEN-1:0] w2_val;
    logic            set_sp;
    logic [IW-1:0]   new_sp_index;

    // Execute results
    logic [XLEN-1:0] res_val;
    logic            res_we;
    logic [XLEN-1:0] next_pc;
    logic            sp_we;
    logic [XLEN-1:0] next_sp;
    logic [XLEN-1:0] mem_addr;
    size_code_t      mem_size;
    logic [XLEN-1:0] mem_data;
    logic            mem_dir_load;
    logic            ssp_we;
    logic [IW-1:0]   ssp_index;

    // Bus requests
    logic            req_start;
    acc_kind_e       req_kind;
    logic [XLEN-1:0] req_addr;
    size_code_t      req_size;
    logic [XLEN-1:0] req_data;
    logic            done;
    logic [XLEN-1:0] load_value;

    insn_decoder #(.NREG(NREG)) u_decoder (.*);

    xreg_file #(.XLEN(XLEN), .NREG(NREG)) u_xregs (.*);

    exec_unit #(.XLEN(XLEN), .NREG(NREG)) u_exec (.*);

    sequencer #(.XLEN(XLEN), .NREG(NREG)) u_seq (.*);

    mem_port #(.XLEN(XLEN)) u_mem (.*);

endmodule

// ==== testbench/tb_memory.sv ====
`timescale 1ns/1ps

module tb_memory #(
    parameter int XLEN = 64,
    parameter int MEM_BYTES = 512,
    parameter int SEED = 1
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] addr,
    input  logic            wr,
    input  logic            ce,
    input  logic [7:0]      wr_data,
    output logic [7:0]      rd_data,
    output logic            rdy
);
    localparam int AW = $clog2(MEM_BYTES);

    logic [7:0] mem [MEM_BYTES];

    assign rd_data = mem[addr[AW-1:0]];  // Address is registered in the DUT

    // Background pattern, every address bit takes part
    task automatic fill();
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'(i * 37) ^ 8'(i >> 8) ^ 8'hA5;
        end
    endtask

    task automatic poke(input int a, input logic [7:0] d);
        mem[a] = d;
    endtask

    // Random stalls, roughly one cycle in four
    initial begin
        void'($urandom(SEED));
        rdy = 1'b0;
        forever begin
            @(posedge clk);
            #1 rdy = rst ? 1'b0 : (($urandom % 4) != 0);
        end
    end

    always @(posedge clk) begin
        if (ce && wr && rdy) begin
            mem[addr[AW-1:0]] <= wr_data;
        end
    end

endmodule

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();
    localparam int XLEN = 64;
    localparam int NREG = 16;
    localparam int MEM_BYTES = 512;
    localparam int CLK_PERIOD = 100;
    localparam int SEED = 1438;
    localparam a_op_e ALU_OPS[12] = '{A_ADD, A_SUS, A_AND, A_IOR, A_XOR, A_INC,
                                      A_DEC, A_IN2, A_DE2, A_NOT, A_FLP, A_AUS};

    logic            clk;
    logic            rst;
    logic [7:0]      rd_data;
    logic            rdy;
    logic [XLEN-1:0] addr;
    logic            wr;
    logic            ce;
    logic [7:0]      wr_data;

    logic [XLEN-1:0] exp_addr_q[$];
    logic [7:0]      exp_data_q[$];
    string           exp_name_q[$];
    bit              skip_mark[MEM_BYTES];  // Code bytes that must never be fetched
    logic [63:0]     xm[NREG];              // Expected register contents
    logic [63:0]     sp;
    int              prog_len;
    int              budget;
    bit              prog_ready;
    bit              first_seen;

    cpu_top #(.XLEN(XLEN), .NREG(NREG)) dut0 (
        .clk(clk), .rst(rst), .rd_data(rd_data), .rdy(rdy),
        .addr(addr), .wr(wr), .ce(ce), .wr_data(wr_data)
    );

    tb_memory #(.XLEN(XLEN), .MEM_BYTES(MEM_BYTES), .SEED(SEED)) mem0 (
        .clk(clk), .rst(rst), .addr(addr), .wr(wr), .ce(ce),
        .wr_data(wr_data), .rd_data(rd_data), .rdy(rdy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic logic [63:0] alu_model(input a_op_e op, input logic [63:0] a,
                                              input logic [63:0] b);
        case (op)
            A_ADD, A_AUS: return a + b;
            A_SUS: return a - b;
            A_AND: return a & b;
            A_IOR: return a | b;
            A_XOR: return a ^ b;
            A_INC: return a + 64'd1;
            A_DEC: return a - 64'd1;
            A_IN2: return a + 64'd2;
            A_DE2: return a - 64'd2;
            A_NOT: return ~a;
            A_FLP: return a ^ (64'd1 << 63);
            A_HLF: return a & 64'hFFFF_FFFF;
            A_HIF: return a & ~64'hFFFF_FFFF;
            default: return 64'd0;
        endcase
    endfunction

    task automatic emit_a(input int r, input a_op_e op);
        mem0.poke(prog_len, {4'(r), op});
        prog_len++;
    endtask

    task automatic emit_b(input int r, input b_op_e code);
        emit_a(r, A_VVV);
        mem0.poke(prog_len, code);
        prog_len++;
    endtask

    task automatic alu_step(input int r, input a_op_e op);
        emit_a(r, op);
        xm[(r + 2) % NREG] = alu_model(op, xm[r], xm[(r + 1) % NREG]);
    endtask

    task automatic imm(input int r);
        emit_b(r, B_IMM);
        xm[(r + 2) % NREG] = 64'(16 * r + (r + 1) % NREG);
    endtask

    task automatic ccc(input int r);
        emit_b(r, B_CCC);
        xm[(r + 2) % NREG] = 64'd0;
    endtask

    // Low byte first at ascending addresses
    task automatic expect_store(input string name, input logic [63:0] base,
                                input logic [63:0] value, input int nbytes);
        for (int k = 0; k < nbytes; k++) begin
            exp_addr_q.push_back(base + 64'(k));
            exp_data_q.push_back(value[8*k +: 8]);
            exp_name_q.push_back(name);
        end
    endtask

    task automatic push_reg(input string name, input int r, input b_op_e code, input int nbytes);
        emit_b(r, code);
        expect_store(name, sp, xm[r], nbytes);
        sp = sp + 64'(nbytes);
    endtask

    // Taken branch jumps over the marker block to the join
    task automatic branch_test(input string name, input b_op_e code);
        bit taken;
        case (code)
            B_BEQ: taken = (xm[9] == xm[10]);
            B_BNE: taken = (xm[9] != xm[10]);
            B_BFR: taken = (xm[9] == 64'd0);
            default: taken = (xm[9] != 64'd0);
        endcase
        emit_b(9, code);
        if (taken) begin
            for (int k = 0; k < 4; k++) skip_mark[prog_len + k] = 1'b1;
        end
        xm[12] = 64'(prog_len + 1);
        emit_b(10, B_GPC);
        emit_b(12, B_PSQ);
        if (!taken) begin
            expect_store({name, "_marker"}, sp, xm[12], 8);
            sp = sp + 64'd8;
        end
        xm[12] = 64'(prog_len + 1);
        emit_b(10, B_GPC);
        push_reg({name, "_join"}, 12, B_PSQ, 8);
    endtask

    task automatic build_program();
        int g;
        imm(15);  // SP lands at 0xF0
        sp = xm[1];
        imm(2);
        imm(3);
        foreach (ALU_OPS[i]) begin
            alu_step(4, ALU_OPS[i]);
            push_reg(ALU_OPS[i].name(), 6, B_PSQ, 8);
        end
        emit_b(4, B_LS8);
        xm[6] = xm[4] << 8;
        push_reg("ls8", 6, B_PSQ, 8);
        alu_step(4, A_NOT);
        alu_step(6, A_HIF);
        push_reg("hif", 8, B_PSQ, 8);
        alu_step(6, A_HLF);
        push_reg("hlf", 8, B_PSQ, 8);
        push_reg("psb", 4, B_PSB, 1);
        push_reg("pss", 5, B_PSS, 2);
        push_reg("psw", 8, B_PSW, 4);
        push_reg("round_trip_push", 8, B_PSQ, 8);
        emit_b(6, B_QSQ);
        xm[6] = xm[8];
        sp = sp - 64'd8;
        push_reg("round_trip_again", 6, B_PSQ, 8);
        imm(8);
        imm(9);
        alu_step(10, A_ADD);
        imm(11);
        emit_b(12, B_SSW);
        expect_store("ssw", xm[12] + xm[13], xm[12], 4);
        alu_step(12, A_NOT);  // Stale high bits in the load target
        emit_b(12, B_LSS);
        xm[14] = xm[12] & 64'hFFFF;
        push_reg("lss_zero_ext", 14, B_PSQ, 8);
        ccc(4);
        alu_step(6, A_IN2);
        alu_step(8, A_INC);
        ccc(5);
        alu_step(7, A_IN2);
        alu_step(9, A_ADD);  // Branch offset 5 in X11
        branch_test("beq_ne", B_BEQ);
        branch_test("bne_ne", B_BNE);
        branch_test("bnr_nz", B_BNR);
        branch_test("bfr_nz", B_BFR);
        alu_step(8, A_AND);
        branch_test("beq_eq", B_BEQ);
        branch_test("bne_eq", B_BNE);
        ccc(7);
        branch_test("bfr_z", B_BFR);
        branch_test("bnr_z", B_BNR);
        g = prog_len;
        emit_b(8, B_GPC);
        alu_step(10, A_ADD);
        emit_b(12, B_JMR);
        skip_mark[prog_len] = 1'b1;
        emit_a(12, A_NOT);
        xm[14] = 64'(g + 5);
        push_reg("jmr_link", 14, B_PSQ, 8);
    endtask

    initial begin
        rst = 1'b1;
        prog_len = 0;
        prog_ready = 1'b0;
        first_seen = 1'b0;
        foreach (xm[i]) xm[i] = 64'd0;
        mem0.fill();
        build_program();
        // About 8 cycles per bus byte and 4x slack for stalls
        budget = (prog_len + exp_addr_q.size() + 16) * 8 * 4;
        prog_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

    initial begin
        wait (prog_ready);
        repeat (budget) @(posedge clk);
        fail_run($sformatf("Timeout after %0d cycles with %0d writes outstanding",
                           budget, exp_addr_q.size()));
    end

    a_quiet_reset: assert property (@(posedge clk) rst |=> (!ce && !wr))
        else fail_run("ce or wr active during or right after reset");

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        ce && !rdy |=> $stable(addr) && $stable(wr) && $stable(wr_data))
        else fail_run("Bus outputs changed during a stall");

    always @(posedge clk) begin
        if (!rst && ce && !first_seen) begin
            first_seen = 1'b1;
            assert (!wr && addr == '0)
                else fail_run("First bus access is not a read of address 0");
        end
        if (!rst && ce && !wr && rdy && addr < MEM_BYTES) begin
            assert (!skip_mark[int'(addr)])
                else fail_run($sformatf("Fetch from skipped code address %h", addr));
        end
        if (!rst && ce && wr && rdy && exp_addr_q.size() != 0) begin
            assert (addr == exp_addr_q[0])
                else fail_run($sformatf("Mismatch %s address: expected %h, actual %h",
                                        exp_name_q[0], exp_addr_q[0], addr));
            assert (wr_data == exp_data_q[0])
                else fail_run($sformatf("Mismatch %s data: expected %h, actual %h",
                                        exp_name_q[0], exp_data_q[0], wr_data));
            void'(exp_addr_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_name_q.pop_front());
            if (exp_addr_q.size() == 0) begin
                $display("Test completed successfully");
                $finish;
            end
        end
    end

endmodule

// ==== tb.f ====
design/cpu_pkg.sv
design/insn_decoder.sv
design/xreg_file.sv
design/exec_unit.sv
design/sequencer.sv
design/mem_port.sv
design/cpu_top.sv
testbench/tb_memory.sv
testbench/cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cpu_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_TEXT ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
